// File: design/mem_settings.svh
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// datapath word width in bits
`define DATA_WIDTH 32

// byte lanes per word, one strobe bit each
`define BYTE_LANES (`DATA_WIDTH / 8)

// word-address bits of the data RAM
// 10 gives 1024 words (4 KiB)
`define RAM_ADDR_WIDTH 10

`endif

// File: design/memPkg.sv
`include "mem_settings.svh"

package memPkg;

    typedef logic [`DATA_WIDTH-1:0] word_t;
    typedef logic [`BYTE_LANES-1:0] strobe_t;
    typedef logic [4:0] regIdx_t;

    // access size of a load or store
    typedef enum logic [1:0] {
        MSIZE1 = 2'b00,
        MSIZE2 = 2'b01,
        MSIZE4 = 2'b10
    } msize_e;

    // kind of cp0 event carried by an instruction
    typedef enum logic [1:0] {
        NONE      = 2'b00,
        EXCEPTION = 2'b01,
        INTERRUPT = 2'b10,
        ERET      = 2'b11
    } ctype_e;

    typedef struct packed {
        logic   regWrite;
        logic   memToReg;
        logic   memWrite;
        logic   loadSigned;
        logic   hiWrite;
        logic   loWrite;
        logic   cp0Write;
        msize_e msize;
    } memCtl_t;

    typedef struct packed {
        ctype_e ctype;
        logic   valid;
        // address error on load / on store
        logic   adel;
        logic   ades;
        // offending virtual address
        word_t  vaddr;
    } cp0Ctl_t;

    // record handed over from execute
    typedef struct packed {
        logic    valid;
        word_t   pc;
        regIdx_t rdst;
        word_t   aluOut;
        word_t   srcb;
        memCtl_t ctl;
        cp0Ctl_t cp0Ctl;
    } laneData_t;

    typedef struct packed {
        logic    valid;
        word_t   addr;
        msize_e  size;
        strobe_t strobe;
        word_t   data;
    } dbusReq_t;

    typedef struct packed {
        logic    valid;
        word_t   pc;
        regIdx_t rdst;
        logic    regWrite;
        word_t   result;
        cp0Ctl_t cp0Ctl;
    } wbLane_t;

endpackage

// File: design/addrTranslate.sv
`timescale 1ns/1ps

module addrTranslate import memPkg::*; (
    input  word_t vaddr,
    output word_t paddr
);

    logic [2:0] segment;
    logic       unmapped;

    assign segment = vaddr[31:29];

    always_comb begin
        // kseg0 is 0x8000_0000..0x9fff_ffff, kseg1 is 0xa000_0000..0xbfff_ffff
        case (segment)
            3'b100,
            3'b101:  unmapped = 1'b1;
            default: unmapped = 1'b0;
        endcase
    end

    always_comb begin
        paddr = vaddr;
        // both unmapped segments alias the low 512 MiB
        if (unmapped) begin
            paddr[31:29] = 3'b000;
        end
    end

endmodule

// File: design/storeAlign.sv
`timescale 1ns/1ps

module storeAlign import memPkg::*; (
    input  logic [1:0] addrLow,
    input  word_t      storeData,
    input  msize_e     msize,
    output word_t      alignedData,
    output strobe_t    strobe,
    output logic       storeMisalign
);

    always_comb begin
        case (msize)
            MSIZE1: begin
                // byte copied to every lane, strobe picks the one
                alignedData   = {4{storeData[7:0]}};
                strobe        = strobe_t'(4'b0001) << addrLow;
                storeMisalign = 1'b0;
            end
            MSIZE2: begin
                alignedData   = {2{storeData[15:0]}};
                strobe        = strobe_t'(4'b0011) << addrLow;
                storeMisalign = addrLow[0];
            end
            MSIZE4: begin
                alignedData   = storeData;
                strobe        = strobe_t'(4'b1111);
                storeMisalign = |addrLow;
            end
            default: begin
                // unused size code writes nothing
                alignedData   = storeData;
                strobe        = '0;
                storeMisalign = 1'b0;
            end
        endcase
    end

endmodule

// File: design/memoryStage.sv
`timescale 1ns/1ps

module memoryStage import memPkg::*; (
    input  laneData_t dataE  [1:0],
    output laneData_t dataE2 [1:0],
    output dbusReq_t  dreq   [1:0],
    output logic      excpM
);

    word_t   paddr        [1:0];
    word_t   alignedData  [1:0];
    strobe_t strobe       [1:0];
    logic    sizeMisalign [1:0];
    logic    storeMis     [1:0];
    logic    loadMis      [1:0];
    logic    blocked      [1:0];
    logic    laneEvent    [1:0];
    logic    olderKill;

    for (genvar i = 0; i < 2; i++) begin : gLane
        addrTranslate u_addrTranslate (
            .vaddr(dataE[i].aluOut),
            .paddr(paddr[i])
        );

        storeAlign u_storeAlign (
            .addrLow      (dataE[i].aluOut[1:0]),
            .storeData    (dataE[i].srcb),
            .msize        (dataE[i].ctl.msize),
            .alignedData  (alignedData[i]),
            .strobe       (strobe[i]),
            .storeMisalign(sizeMisalign[i])
        );

        // same size rule applies to loads and stores
        assign storeMis[i] = dataE[i].valid && dataE[i].ctl.memWrite && sizeMisalign[i];
        assign loadMis[i]  = dataE[i].valid && dataE[i].ctl.memToReg && sizeMisalign[i];

        // instruction already faulting or returning, no bus access
        assign blocked[i] = dataE[i].cp0Ctl.ctype == EXCEPTION ||
                            dataE[i].cp0Ctl.ctype == ERET ||
                            storeMis[i] || loadMis[i];

        // any cp0 event kind other than none
        assign laneEvent[i] = dataE[i].cp0Ctl.ctype != NONE;

        always_comb begin
            dreq[i] = '0;
            if (dataE[i].valid && (dataE[i].ctl.memToReg || dataE[i].ctl.memWrite)) begin
                dreq[i].valid = !blocked[i] && (i == 1 || !olderKill);
                dreq[i].addr  = paddr[i];
                dreq[i].size  = dataE[i].ctl.msize;
                if (dataE[i].ctl.memWrite) begin
                    dreq[i].strobe = strobe[i];
                    dreq[i].data   = alignedData[i];
                end
            end
        end

        always_comb begin
            dataE2[i] = dataE[i];
            if (storeMis[i]) begin
                dataE2[i].cp0Ctl.ctype = EXCEPTION;
                dataE2[i].cp0Ctl.valid = 1'b1;
                dataE2[i].cp0Ctl.ades  = 1'b1;
                dataE2[i].cp0Ctl.vaddr = dataE[i].aluOut;
            end
            if (loadMis[i]) begin
                dataE2[i].cp0Ctl.ctype = EXCEPTION;
                dataE2[i].cp0Ctl.valid = 1'b1;
                dataE2[i].cp0Ctl.adel  = 1'b1;
                dataE2[i].cp0Ctl.vaddr = dataE[i].aluOut;
            end
            // younger lane loses all architectural writes
            if (i == 0 && olderKill) begin
                dataE2[i].ctl.regWrite = 1'b0;
                dataE2[i].ctl.memToReg = 1'b0;
                dataE2[i].ctl.hiWrite  = 1'b0;
                dataE2[i].ctl.loWrite  = 1'b0;
                dataE2[i].ctl.cp0Write = 1'b0;
                dataE2[i].cp0Ctl.valid = 1'b0;
            end
        end
    end

    // lane 1 is older, its fault squashes lane 0
    assign olderKill = blocked[1];

    assign excpM = laneEvent[1] || laneEvent[0] ||
                   storeMis[1] || storeMis[0] ||
                   loadMis[1]  || loadMis[0];

endmodule

// File: design/dataRam.sv
`timescale 1ns/1ps

`include "mem_settings.svh"

module dataRam import memPkg::*; (
    input  logic     clk,
    input  dbusReq_t dreq  [1:0],
    output word_t    rdata [1:0]
);

    localparam int Depth = 2 ** `RAM_ADDR_WIDTH;

    word_t mem [Depth];

    logic [`RAM_ADDR_WIDTH-1:0] wordIdx [1:0];
    logic                       isWrite [1:0];
    logic                       isRead  [1:0];

    for (genvar i = 0; i < 2; i++) begin : gPort
        // word index from physical address, upper bits wrap
        assign wordIdx[i] = dreq[i].addr[`RAM_ADDR_WIDTH+1:2];
        assign isWrite[i] = dreq[i].valid && (|dreq[i].strobe);
        assign isRead[i]  = dreq[i].valid && !(|dreq[i].strobe);
    end

    // writes in lane order 1 then 0
    // the later nonblocking update wins, so lane 0 owns a shared byte
    always_ff @(posedge clk) begin
        for (int l = 1; l >= 0; l--) begin
            if (isWrite[l]) begin
                for (int b = 0; b < `BYTE_LANES; b++) begin
                    if (dreq[l].strobe[b]) begin
                        mem[wordIdx[l]][8*b +: 8] <= dreq[l].data[8*b +: 8];
                    end
                end
            end
        end
    end

    // registered read, sees the word before this edge's writes
    always_ff @(posedge clk) begin
        for (int l = 0; l < 2; l++) begin
            if (isRead[l]) begin
                rdata[l] <= mem[wordIdx[l]];
            end
        end
    end

endmodule

// File: design/loadExtract.sv
`timescale 1ns/1ps

module loadExtract import memPkg::*; (
    input  laneData_t lane,
    input  word_t     rdata,
    output wbLane_t   wb
);

    logic [7:0]  loadByte;
    logic [15:0] loadHalf;
    word_t       loadValue;

    always_comb begin
        // byte lane from the low address bits
        case (lane.aluOut[1:0])
            2'd0: loadByte = rdata[7:0];
            2'd1: loadByte = rdata[15:8];
            2'd2: loadByte = rdata[23:16];
            default: loadByte = rdata[31:24];
        endcase
        loadHalf = lane.aluOut[1] ? rdata[31:16] : rdata[15:0];
    end

    always_comb begin
        case (lane.ctl.msize)
            MSIZE1: begin
                if (lane.ctl.loadSigned) begin
                    loadValue = {{24{loadByte[7]}}, loadByte};
                end else begin
                    loadValue = {24'b0, loadByte};
                end
            end
            MSIZE2: begin
                if (lane.ctl.loadSigned) begin
                    loadValue = {{16{loadHalf[15]}}, loadHalf};
                end else begin
                    loadValue = {16'b0, loadHalf};
                end
            end
            default: loadValue = rdata;
        endcase
    end

    always_comb begin
        wb.valid    = lane.valid;
        wb.pc       = lane.pc;
        wb.rdst     = lane.rdst;
        wb.regWrite = lane.ctl.regWrite;
        // non-loads forward the ALU result
        wb.result   = lane.ctl.memToReg ? loadValue : lane.aluOut;
        wb.cp0Ctl   = lane.cp0Ctl;
    end

endmodule

// File: design/memSubsystem.sv
`timescale 1ns/1ps

module memSubsystem import memPkg::*; (
    input  logic      clk,
    input  logic      arstN,
    input  laneData_t exeLane [1:0],
    output wbLane_t   wbLane  [1:0],
    output logic      excpM
);

    laneData_t memLane  [1:0];
    laneData_t laneQ    [1:0];
    laneData_t regLane  [1:0];
    dbusReq_t  dreq     [1:0];
    word_t     rdata    [1:0];
    logic      validQ   [1:0];
    logic      regWriteQ[1:0];

    memoryStage u_memoryStage (
        .dataE (exeLane),
        .dataE2(memLane),
        .dreq  (dreq),
        .excpM (excpM)
    );

    dataRam u_dataRam (
        .clk  (clk),
        .dreq (dreq),
        .rdata(rdata)
    );

    for (genvar i = 0; i < 2; i++) begin : gLane
        // control bits of the mem/wb register
        always_ff @(posedge clk or negedge arstN) begin
            if (!arstN) begin
                validQ[i]    <= 1'b0;
                regWriteQ[i] <= 1'b0;
            end else begin
                validQ[i]    <= memLane[i].valid;
                regWriteQ[i] <= memLane[i].ctl.regWrite;
            end
        end

        // rest of the record
        always_ff @(posedge clk) begin
            laneQ[i] <= memLane[i];
        end

        always_comb begin
            regLane[i]              = laneQ[i];
            regLane[i].valid        = validQ[i];
            regLane[i].ctl.regWrite = regWriteQ[i];
        end

        loadExtract u_loadExtract (
            .lane (regLane[i]),
            .rdata(rdata[i]),
            .wb   (wbLane[i])
        );
    end

endmodule

// File: sim/tbMemSubsystem.sv
`timescale 1ns/1ps

`include "mem_settings.svh"

module tbMemSubsystem import memPkg::*; ();

    localparam int ResetCycles   = 4;
    localparam int RandIters     = 40;
    localparam int DirectedPairs = 33;
    // one cycle per pair plus slack
    localparam int MaxCycles     = ResetCycles + DirectedPairs + 3 * RandIters + 100;
    localparam int RefBytes      = 2 ** (`RAM_ADDR_WIDTH + 2);

    typedef logic [`RAM_ADDR_WIDTH+1:0] byteAddr_t;

    logic      clk;
    logic      arstN;
    laneData_t exeLane [1:0];
    wbLane_t   wbLane  [1:0];
    logic      excpM;

    // byte-wide reference copy of the data RAM
    logic [7:0]  refMem [RefBytes];
    logic [15:0] lfsr = 16'd23;
    string       curTest;
    int          errCount = 0;
    int          errStart = 0;
    int          passTests = 0;
    int          failTests = 0;
    int          cycleCount = 0;
    int          opSeq = 0;

    memSubsystem i_memSubsystem (
        .clk    (clk),
        .arstN  (arstN),
        .exeLane(exeLane),
        .wbLane (wbLane),
        .excpM  (excpM)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > MaxCycles) begin
            $display("timeout: run still going after %0d cycles", MaxCycles);
            $display("Test failed");
            $finish;
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic nextBit();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic word_t randBits(input int n);
        word_t r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r = {r[30:0], nextBit()};
        end
        return r;
    endfunction

    // kseg0 and kseg1 both alias the low 512 MiB
    function automatic word_t physAddr(input word_t va);
        if (va >= 32'h8000_0000 && va <= 32'hBFFF_FFFF) begin
            return va & 32'h1FFF_FFFF;
        end
        return va;
    endfunction

    function automatic int sizeBytes(input msize_e size);
        case (size)
            MSIZE2:  return 2;
            MSIZE4:  return 4;
            default: return 1;
        endcase
    endfunction

    function automatic logic isMisaligned(input laneData_t op);
        int offset;
        offset = int'(op.aluOut[1:0]);
        return op.valid && (op.ctl.memToReg || op.ctl.memWrite) &&
               (offset % sizeBytes(op.ctl.msize)) != 0;
    endfunction

    function automatic logic issues(input laneData_t op, input logic squashed);
        return op.valid && (op.ctl.memToReg || op.ctl.memWrite) && !isMisaligned(op) &&
               op.cp0Ctl.ctype != EXCEPTION && op.cp0Ctl.ctype != ERET && !squashed;
    endfunction

    function automatic laneData_t makeOp(input logic isLoad, input logic isStore,
                                         input msize_e size, input logic isSigned,
                                         input word_t addr, input word_t data);
        laneData_t op;
        op = '0;
        opSeq++;
        op.valid          = 1'b1;
        op.pc             = 32'h0040_0000 + (word_t'(opSeq) << 2);
        op.rdst           = opSeq[4:0];
        op.aluOut         = addr;
        op.srcb           = data;
        op.ctl.regWrite   = isLoad;
        op.ctl.memToReg   = isLoad;
        op.ctl.memWrite   = isStore;
        op.ctl.loadSigned = isSigned;
        op.ctl.msize      = size;
        return op;
    endfunction

    function automatic laneData_t loadOp(input msize_e size, input logic isSigned,
                                         input word_t addr);
        return makeOp(1'b1, 1'b0, size, isSigned, addr, '0);
    endfunction

    function automatic laneData_t storeOp(input msize_e size, input word_t addr,
                                          input word_t data);
        return makeOp(1'b0, 1'b1, size, 1'b0, addr, data);
    endfunction

    // non-memory op carrying a cp0 event
    function automatic laneData_t eventOp(input ctype_e kind);
        laneData_t op;
        op = makeOp(1'b0, 1'b0, MSIZE4, 1'b0, 32'h1234_0000, '0);
        op.cp0Ctl.ctype = kind;
        op.cp0Ctl.valid = 1'b1;
        return op;
    endfunction

    // bytes gathered little endian from the lowest address up
    function automatic word_t readRef(input word_t va, input msize_e size, input logic isSigned);
        word_t     pa;
        byteAddr_t b;
        word_t     val;
        int        n;
        pa  = physAddr(va);
        b   = pa[`RAM_ADDR_WIDTH+1:0];
        n   = sizeBytes(size);
        val = '0;
        for (int k = 0; k < n; k++) begin
            val = val | (word_t'(refMem[b]) << (8 * k));
            b = b + byteAddr_t'(1);
        end
        if (n == 1 && isSigned) begin
            val = {{24{val[7]}}, val[7:0]};
        end
        if (n == 2 && isSigned) begin
            val = {{16{val[15]}}, val[15:0]};
        end
        return val;
    endfunction

    task automatic writeRef(input word_t va, input msize_e size, input word_t data);
        word_t     pa;
        byteAddr_t b;
        word_t     rest;
        pa   = physAddr(va);
        b    = pa[`RAM_ADDR_WIDTH+1:0];
        rest = data;
        for (int k = 0; k < sizeBytes(size); k++) begin
            refMem[b] = rest[7:0];
            rest = rest >> 8;
            b = b + byteAddr_t'(1);
        end
    endtask

    task automatic predictLane(input laneData_t op, input logic squashed,
                               output wbLane_t wb, output logic resultKnown);
        logic loadLive;
        wb.valid    = op.valid;
        wb.pc       = op.pc;
        wb.rdst     = op.rdst;
        wb.regWrite = op.ctl.regWrite && !squashed;
        wb.cp0Ctl   = op.cp0Ctl;
        if (isMisaligned(op)) begin
            wb.cp0Ctl.ctype = EXCEPTION;
            wb.cp0Ctl.valid = 1'b1;
            wb.cp0Ctl.vaddr = op.aluOut;
            wb.cp0Ctl.adel  = wb.cp0Ctl.adel | op.ctl.memToReg;
            wb.cp0Ctl.ades  = wb.cp0Ctl.ades | op.ctl.memWrite;
        end
        if (squashed) begin
            wb.cp0Ctl.valid = 1'b0;
        end
        // a load that never reached the RAM has no defined result
        loadLive    = op.ctl.memToReg && !squashed;
        resultKnown = !loadLive || issues(op, squashed);
        wb.result   = loadLive ? readRef(op.aluOut, op.ctl.msize, op.ctl.loadSigned) : op.aluOut;
    endtask

    task automatic checkValue(input string field, input word_t expected, input word_t actual);
        assert (actual === expected) else begin
            errCount++;
            $display("mismatch %s %s: expected %h actual %h", curTest, field, expected, actual);
        end
    endtask

    task automatic checkLane(input string name, input wbLane_t exp, input logic resultKnown,
                             input wbLane_t act);
        checkValue({name, " valid"}, word_t'(exp.valid), word_t'(act.valid));
        checkValue({name, " regWrite"}, word_t'(exp.regWrite), word_t'(act.regWrite));
        checkValue({name, " pc"}, exp.pc, act.pc);
        checkValue({name, " rdst"}, word_t'(exp.rdst), word_t'(act.rdst));
        checkValue({name, " cp0 valid"}, word_t'(exp.cp0Ctl.valid), word_t'(act.cp0Ctl.valid));
        checkValue({name, " ctype"}, word_t'(exp.cp0Ctl.ctype), word_t'(act.cp0Ctl.ctype));
        checkValue({name, " adel"}, word_t'(exp.cp0Ctl.adel), word_t'(act.cp0Ctl.adel));
        checkValue({name, " ades"}, word_t'(exp.cp0Ctl.ades), word_t'(act.cp0Ctl.ades));
        checkValue({name, " vaddr"}, exp.cp0Ctl.vaddr, act.cp0Ctl.vaddr);
        if (resultKnown) begin
            checkValue({name, " result"}, exp.result, act.result);
        end
    endtask

    // runs from one falling edge to the next so consecutive pairs overlap
    task automatic runPair(input laneData_t op1, input laneData_t op0);
        wbLane_t exp1;
        wbLane_t exp0;
        logic    known1;
        logic    known0;
        logic    olderKill;
        logic    expExcp;
        olderKill = isMisaligned(op1) || op1.cp0Ctl.ctype == EXCEPTION ||
                    op1.cp0Ctl.ctype == ERET;
        expExcp = isMisaligned(op1) || isMisaligned(op0) ||
                  op1.cp0Ctl.ctype != NONE || op0.cp0Ctl.ctype != NONE;
        // reads see the memory before this pair's stores
        predictLane(op1, 1'b0, exp1, known1);
        predictLane(op0, olderKill, exp0, known0);
        if (issues(op1, 1'b0) && op1.ctl.memWrite) begin
            writeRef(op1.aluOut, op1.ctl.msize, op1.srcb);
        end
        // lane 0 goes second and owns shared bytes
        if (issues(op0, olderKill) && op0.ctl.memWrite) begin
            writeRef(op0.aluOut, op0.ctl.msize, op0.srcb);
        end
        exeLane[1] = op1;
        exeLane[0] = op0;
        // excpM in the drive cycle and write-back one cycle later
        #1;
        checkValue("excpM", word_t'(expExcp), word_t'(excpM));
        @(negedge clk);
        checkLane("lane1", exp1, known1, wbLane[1]);
        checkLane("lane0", exp0, known0, wbLane[0]);
        exeLane[1] = '0;
        exeLane[0] = '0;
    endtask

    task automatic runSingle(input logic lane, input laneData_t op);
        if (lane) begin
            runPair(op, '0);
        end else begin
            runPair('0, op);
        end
    endtask

    task automatic beginTest(input string name);
        curTest  = name;
        errStart = errCount;
    endtask

    task automatic endTest();
        if (errCount == errStart) begin
            passTests++;
            $display("test %s: pass", curTest);
        end else begin
            failTests++;
            $display("test %s: %0d errors", curTest, errCount - errStart);
        end
    endtask

    initial begin
        word_t     base;
        word_t     r;
        msize_e    size;
        logic [1:0] off;
        laneData_t victim;
        laneData_t older;

        arstN      = 1'b0;
        exeLane[1] = '0;
        exeLane[0] = '0;
        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);

        beginTest("resetState");
        checkValue("lane1 valid", '0, word_t'(wbLane[1].valid));
        checkValue("lane0 valid", '0, word_t'(wbLane[0].valid));
        checkValue("lane1 regWrite", '0, word_t'(wbLane[1].regWrite));
        checkValue("lane0 regWrite", '0, word_t'(wbLane[0].regWrite));
        arstN = 1'b1;
        endTest();

        beginTest("wordRoundTrip");
        runPair(storeOp(MSIZE4, 32'h100, 32'hDEAD_BEEF), '0);
        runPair(loadOp(MSIZE4, 1'b0, 32'h100), '0);
        runPair('0, storeOp(MSIZE4, 32'h204, 32'h1234_5678));
        runPair(loadOp(MSIZE4, 1'b1, 32'h204), '0);
        endTest();

        beginTest("randomSubword");
        for (int it = 0; it < RandIters; it++) begin
            // whole word first so every later load reads defined bytes
            base = 32'h0000_0400 | (randBits(8) << 2);
            r = randBits(1);
            runSingle(r[0], storeOp(MSIZE4, base, randBits(32)));
            r = randBits(4);
            size = r[2] ? MSIZE2 : MSIZE1;
            off  = r[2] ? {r[1], 1'b0} : r[1:0];
            runSingle(r[3], storeOp(size, base | word_t'(off), randBits(16)));
            r = randBits(5);
            size = r[2] ? MSIZE2 : MSIZE1;
            off  = r[2] ? {r[1], 1'b0} : r[1:0];
            runSingle(r[3], loadOp(size, r[4], base | word_t'(off)));
        end
        endTest();

        beginTest("misaligned");
        runPair(storeOp(MSIZE4, 32'h300, 32'hCAFE_F00D), '0);
        runPair(storeOp(MSIZE4, 32'h302, 32'h1111_1111), '0);
        runPair('0, storeOp(MSIZE2, 32'h301, 32'h0000_2222));
        runPair(loadOp(MSIZE4, 1'b0, 32'h303), '0);
        runPair('0, loadOp(MSIZE2, 1'b1, 32'h305));
        runPair('0, loadOp(MSIZE4, 1'b0, 32'h300));
        endTest();

        beginTest("olderSquash");
        runPair(storeOp(MSIZE4, 32'h500, 32'h0BAD_F00D), '0);
        for (int c = 0; c < 3; c++) begin
            victim = storeOp(MSIZE4, 32'h500, 32'hFFFF_0000 + word_t'(c));
            victim.ctl.regWrite = 1'b1;
            victim.cp0Ctl.valid = 1'b1;
            case (c)
                0:       older = eventOp(EXCEPTION);
                1:       older = eventOp(ERET);
                default: older = loadOp(MSIZE4, 1'b0, 32'h601);
            endcase
            runPair(older, victim);
            runPair('0, loadOp(MSIZE4, 1'b0, 32'h500));
        end
        // an older interrupt is reported but squashes nothing
        runPair(eventOp(INTERRUPT), storeOp(MSIZE4, 32'h504, 32'h600D_CAFE));
        runPair('0, loadOp(MSIZE4, 1'b0, 32'h504));
        endTest();

        beginTest("ksegAlias");
        runPair(storeOp(MSIZE4, 32'hA000_0800, 32'h5A5A_A5A5), '0);
        runPair(loadOp(MSIZE4, 1'b0, 32'h8000_0800), '0);
        runPair('0, loadOp(MSIZE4, 1'b0, 32'h0000_0800));
        runPair('0, storeOp(MSIZE1, 32'h8000_0801, 32'h0000_00C3));
        runPair(loadOp(MSIZE2, 1'b1, 32'hA000_0800), '0);
        endTest();

        beginTest("sameWordMerge");
        runPair(storeOp(MSIZE4, 32'h700, 32'h0000_0000), '0);
        runPair(storeOp(MSIZE4, 32'h700, 32'h1122_3344), storeOp(MSIZE1, 32'h701, 32'h0000_00AB));
        runPair('0, loadOp(MSIZE4, 1'b0, 32'h700));
        runPair(storeOp(MSIZE1, 32'h702, 32'h0000_00EE), storeOp(MSIZE2, 32'h702, 32'h0000_5566));
        runPair(loadOp(MSIZE4, 1'b0, 32'h700), '0);
        runPair(storeOp(MSIZE2, 32'h700, 32'h0000_7788), storeOp(MSIZE4, 32'h700, 32'h99AA_BBCC));
        runPair('0, loadOp(MSIZE4, 1'b0, 32'h700));
        // read beside a write to the same word returns the old word
        runPair(storeOp(MSIZE4, 32'h700, 32'h0102_0304), loadOp(MSIZE4, 1'b0, 32'h700));
        runPair('0, loadOp(MSIZE4, 1'b0, 32'h700));
        endTest();

        $display("summary: %0d tests passed, %0d tests with errors", passTests, failTests);
        if (failTests == 0 && errCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+design
design/memPkg.sv
design/addrTranslate.sv
design/storeAlign.sv
design/memoryStage.sv
design/dataRam.sv
design/loadExtract.sv
design/memSubsystem.sv
sim/tbMemSubsystem.sv

// File: run.sh
#!/bin/sh
# build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tbMemSubsystem -o simMemSubsystem -f project.f
if [ $? -ne 0 ]; then
    echo "verilator build did not complete"
    exit 1
fi

simOutput=$(./obj_dir/simMemSubsystem)
simStatus=$?
printf '%s\n' "$simOutput"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if printf '%s\n' "$simOutput" | grep -qx "Test completed successfully"; then
    exit 0
fi
exit 1
